//--- compile.f
hdl/qsim_geom_pkg.sv
hdl/cplx_pkg.sv
hdl/qsim_issue_if.sv
hdl/qsim_ctrl.sv
hdl/qsim_addr_gen.sv
hdl/cmac_pipe.sv
hdl/qsim_top.sv
verif/qsim_tb.sv

//--- Bender.yml
package:
  name: qsim

sources:
  - hdl/qsim_geom_pkg.sv
  - hdl/cplx_pkg.sv
  - hdl/qsim_issue_if.sv
  - hdl/qsim_ctrl.sv
  - hdl/qsim_addr_gen.sv
  - hdl/cmac_pipe.sv
  - hdl/qsim_top.sv
  - target: simulation
    files:
      - verif/qsim_tb.sv

//--- verif/qsim_tb.sv
// random jobs of 1..4 qubits and 1..6 gates with small parts; memories checked only after each job
`timescale 1ns/1ps

module qsim_tb;

  localparam int NUM_JOBS    = 20;
  localparam int STATE_DEPTH = 1 << qsim_geom_pkg::STATE_ADDR_W;
  localparam int GATE_DEPTH  = 1 << qsim_geom_pkg::GATE_ADDR_W;

  logic clk;
  logic reset_n;
  logic dut_valid;
  logic dut_ready;
  logic in_wr_en;
  logic scr_wr_en;
  logic out_wr_en;
  qsim_geom_pkg::state_addr_t in_rd_addr;
  qsim_geom_pkg::state_addr_t in_wr_addr;
  qsim_geom_pkg::state_addr_t scr_rd_addr;
  qsim_geom_pkg::state_addr_t scr_wr_addr;
  qsim_geom_pkg::state_addr_t out_wr_addr;
  qsim_geom_pkg::gate_addr_t  gate_rd_addr;
  cplx_pkg::word_t in_rd_data = '0;
  cplx_pkg::word_t scr_rd_data = '0;
  cplx_pkg::word_t gate_rd_data = '0;
  cplx_pkg::word_t in_wr_data;
  cplx_pkg::word_t scr_wr_data;
  cplx_pkg::word_t out_wr_data;

  // sram contents and expected state
  cplx_pkg::word_t in_mem   [0:STATE_DEPTH-1];
  cplx_pkg::word_t scr_mem  [0:STATE_DEPTH-1];
  cplx_pkg::word_t out_mem  [0:STATE_DEPTH-1];
  cplx_pkg::word_t gate_mem [0:GATE_DEPTH-1];
  cplx_pkg::cplx_t exp_in   [0:STATE_DEPTH-1];
  cplx_pkg::cplx_t exp_scr  [0:STATE_DEPTH-1];
  cplx_pkg::cplx_t exp_out  [0:STATE_DEPTH-1];

  logic [31:0] lfsr_state = 32'h7fde;
  int cycle_count = 0;
  int cycle_limit = 0;

  qsim_top u_qsim_top (
    .clk          (clk),
    .reset_n      (reset_n),
    .dut_valid    (dut_valid),
    .dut_ready    (dut_ready),
    .in_rd_addr   (in_rd_addr),
    .in_rd_data   (in_rd_data),
    .in_wr_en     (in_wr_en),
    .in_wr_addr   (in_wr_addr),
    .in_wr_data   (in_wr_data),
    .scr_rd_addr  (scr_rd_addr),
    .scr_rd_data  (scr_rd_data),
    .scr_wr_en    (scr_wr_en),
    .scr_wr_addr  (scr_wr_addr),
    .scr_wr_data  (scr_wr_data),
    .out_wr_en    (out_wr_en),
    .out_wr_addr  (out_wr_addr),
    .out_wr_data  (out_wr_data),
    .gate_rd_addr (gate_rd_addr),
    .gate_rd_data (gate_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // --------------------------------------------------
  // sram models, one cycle read latency
  // --------------------------------------------------
  always @(posedge clk) begin
    in_rd_data   <= in_mem[in_rd_addr];
    scr_rd_data  <= scr_mem[scr_rd_addr];
    gate_rd_data <= gate_mem[gate_rd_addr];
    if (in_wr_en === 1'b1) in_mem[in_wr_addr] <= in_wr_data;
    if (scr_wr_en === 1'b1) scr_mem[scr_wr_addr] <= scr_wr_data;
    if (out_wr_en === 1'b1) out_mem[out_wr_addr] <= out_wr_data;
  end

  // run length guard
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) fail_run("timeout, the jobs did not finish in time");
  end

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("STATUS: FAIL");
    $fatal(1, "stopping at first error");
  endtask

  task automatic compare_word(input string name, input cplx_pkg::cplx_t exp,
                              input cplx_pkg::cplx_t act);
    if (act !== exp) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  task automatic compare_bit(input string name, input logic exp, input logic act);
    if (act !== exp) fail_run($sformatf("mismatch %s expected %h actual %h", name, exp, act));
  endtask

  // --------------------------------------------------
  // stimulus source, taps 32 22 2 1
  // --------------------------------------------------
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] rand_bits(input int width);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < width; i++) val = {val[30:0], lfsr_step()};
    return val;
  endfunction

  // parts within +-0.25
  function automatic cplx_pkg::cplx_t rand_cplx();
    logic [31:0] bits;
    logic signed [12:0] raw;
    cplx_pkg::cplx_t val;
    bits   = rand_bits(13);
    raw    = bits[12:0];
    val.re = cplx_pkg::part_t'(raw);
    bits   = rand_bits(13);
    raw    = bits[12:0];
    val.im = cplx_pkg::part_t'(raw);
    return val;
  endfunction

  // exact products, then shift out the fraction and keep 16 bits
  function automatic cplx_pkg::cplx_t cplx_mul(input cplx_pkg::cplx_t a, input cplx_pkg::cplx_t b);
    longint re_full;
    longint im_full;
    cplx_pkg::cplx_t prod;
    re_full = longint'(a.re) * longint'(b.re) - longint'(a.im) * longint'(b.im);
    im_full = longint'(a.re) * longint'(b.im) + longint'(a.im) * longint'(b.re);
    prod.re = cplx_pkg::part_t'(re_full >>> cplx_pkg::FRAC_W);
    prod.im = cplx_pkg::part_t'(im_full >>> cplx_pkg::FRAC_W);
    return prod;
  endfunction

  // --------------------------------------------------
  // job setup and reference model
  // --------------------------------------------------
  task automatic load_job(input int q, input int m);
    int n;
    cplx_pkg::cplx_t src;
    cplx_pkg::cplx_t term;
    cplx_pkg::cplx_t sum;
    n = 1 << q;
    in_mem[0] = cplx_pkg::word_t'((q << qsim_geom_pkg::HDR_Q_LSB) | (m << qsim_geom_pkg::HDR_M_LSB));
    exp_in[0] = in_mem[0];
    for (int i = 1; i <= n; i++) begin
      in_mem[i] = rand_cplx();
      exp_in[i] = in_mem[i];
    end
    for (int a = 0; a < m * n * n; a++) gate_mem[a] = rand_cplx();
    // even gates read input and fill scratchpad, odd gates the reverse
    for (int g = 0; g < m; g++) begin
      for (int r = 0; r < n; r++) begin
        sum = '0;
        for (int c = 0; c < n; c++) begin
          src    = (g % 2 == 0) ? exp_in[1 + c] : exp_scr[c];
          term   = cplx_mul(gate_mem[g * n * n + r * n + c], src);
          sum.re = sum.re + term.re;
          sum.im = sum.im + term.im;
        end
        if (g % 2 == 0) exp_scr[r] = sum;
        else exp_in[1 + r] = sum;
        exp_out[r] = sum;
      end
    end
  endtask

  // idle means ready and no writes
  task automatic check_idle();
    compare_bit("dut_ready", 1'b1, dut_ready);
    compare_bit("in_wr_en", 1'b0, in_wr_en);
    compare_bit("scr_wr_en", 1'b0, scr_wr_en);
    compare_bit("out_wr_en", 1'b0, out_wr_en);
  endtask

  task automatic check_results(input int n);
    compare_word("in_mem[0]", exp_in[0], in_mem[0]);
    for (int r = 0; r < n; r++) begin
      compare_word($sformatf("out_mem[%0d]", r), exp_out[r], out_mem[r]);
      compare_word($sformatf("scr_mem[%0d]", r), exp_scr[r], scr_mem[r]);
      compare_word($sformatf("in_mem[%0d]", r + 1), exp_in[r + 1], in_mem[r + 1]);
    end
  endtask

  task automatic run_job(input int q, input int m, input int gap);
    int n;
    n = 1 << q;
    load_job(q, m);
    repeat (gap) begin
      @(posedge clk);
      dut_valid <= 1'b0;
      @(negedge clk);
      check_idle();
    end
    @(posedge clk);
    dut_valid <= 1'b1;
    @(negedge clk);
    check_idle();
    // stray valid pulses while busy, well inside the first gate
    repeat (n * n) begin
      @(posedge clk);
      dut_valid <= lfsr_step();
      @(negedge clk);
      compare_bit("dut_ready", 1'b0, dut_ready);
    end
    @(posedge clk);
    dut_valid <= 1'b0;
    @(negedge clk);
    while (dut_ready !== 1'b1) begin
      @(negedge clk);
    end
    check_results(n);
  endtask

  // --------------------------------------------------
  // main sequence
  // --------------------------------------------------
  initial begin
    int q_list [NUM_JOBS];
    int m_list [NUM_JOBS];
    int gap_list [NUM_JOBS];
    int n;
    reset_n   = 1'b0;
    dut_valid = 1'b0;
    cycle_limit = 200;
    for (int j = 0; j < NUM_JOBS; j++) begin
      q_list[j]   = rand_bits(2) + 1;
      m_list[j]   = rand_bits(3) % 6 + 1;
      gap_list[j] = rand_bits(3);
      n = 1 << q_list[j];
      cycle_limit += 2 * (m_list[j] * (n * n + 8) + 10);
    end
    repeat (10) @(posedge clk);
    reset_n <= 1'b1;
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_idle();
    end
    for (int j = 0; j < NUM_JOBS; j++) run_job(q_list[j], m_list[j], gap_list[j]);
    // nothing may be written once ready is back
    repeat (4) begin
      @(posedge clk);
      @(negedge clk);
      check_idle();
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

//--- hdl/qsim_top.sv
// all SRAMs synchronous with one-cycle read latency; gate SRAM read-only, output SRAM write-only
`timescale 1ns/1ps

module qsim_top (
  input  logic                       clk,
  input  logic                       reset_n,
  input  logic                       dut_valid,
  output logic                       dut_ready,
  // input state SRAM, header at address 0
  output qsim_geom_pkg::state_addr_t in_rd_addr,
  input  cplx_pkg::word_t            in_rd_data,
  output logic                       in_wr_en,
  output qsim_geom_pkg::state_addr_t in_wr_addr,
  output cplx_pkg::word_t            in_wr_data,
  // scratchpad
  output qsim_geom_pkg::state_addr_t scr_rd_addr,
  input  cplx_pkg::word_t            scr_rd_data,
  output logic                       scr_wr_en,
  output qsim_geom_pkg::state_addr_t scr_wr_addr,
  output cplx_pkg::word_t            scr_wr_data,
  // output state SRAM
  output logic                       out_wr_en,
  output qsim_geom_pkg::state_addr_t out_wr_addr,
  output cplx_pkg::word_t            out_wr_data,
  // gate SRAM
  output qsim_geom_pkg::gate_addr_t  gate_rd_addr,
  input  cplx_pkg::word_t            gate_rd_data
);

  qsim_geom_pkg::qubit_cnt_t num_qubits;
  logic hdr_rd;
  logic job_start;
  logic gate_start;
  logic src_scr;
  logic gen_busy;
  logic pipe_busy;

  // element tags from generator to pipeline
  qsim_issue_if issue_bus ();

  // --------------------------------------------------
  // sequencing
  // --------------------------------------------------
  qsim_ctrl u_ctrl (
    .clk        (clk),
    .reset_n    (reset_n),
    .dut_valid  (dut_valid),
    .dut_ready  (dut_ready),
    .in_rd_data (in_rd_data),
    .gen_busy   (gen_busy),
    .pipe_busy  (pipe_busy),
    .hdr_rd     (hdr_rd),
    .num_qubits (num_qubits),
    .job_start  (job_start),
    .gate_start (gate_start),
    .src_scr    (src_scr)
  );

  // read side
  qsim_addr_gen u_addr_gen (
    .clk          (clk),
    .reset_n      (reset_n),
    .num_qubits   (num_qubits),
    .job_start    (job_start),
    .gate_start   (gate_start),
    .src_scr      (src_scr),
    .hdr_rd       (hdr_rd),
    .gen_busy     (gen_busy),
    .in_rd_addr   (in_rd_addr),
    .scr_rd_addr  (scr_rd_addr),
    .gate_rd_addr (gate_rd_addr),
    .issue        (issue_bus.gen)
  );

  // arithmetic and write side
  cmac_pipe u_cmac_pipe (
    .clk          (clk),
    .reset_n      (reset_n),
    .issue        (issue_bus.pipe),
    .src_scr      (src_scr),
    .in_rd_data   (in_rd_data),
    .scr_rd_data  (scr_rd_data),
    .gate_rd_data (gate_rd_data),
    .pipe_busy    (pipe_busy),
    .in_wr_en     (in_wr_en),
    .in_wr_addr   (in_wr_addr),
    .in_wr_data   (in_wr_data),
    .scr_wr_en    (scr_wr_en),
    .scr_wr_addr  (scr_wr_addr),
    .scr_wr_data  (scr_wr_data),
    .out_wr_en    (out_wr_en),
    .out_wr_addr  (out_wr_addr),
    .out_wr_data  (out_wr_data)
  );

endmodule

//--- hdl/cmac_pipe.sv
// fixed 3-cycle tag-to-write latency; src_scr must hold until the pipe drains
`timescale 1ns/1ps

module cmac_pipe (
  input  logic                       clk,
  input  logic                       reset_n,
  qsim_issue_if.pipe                 issue,
  input  logic                       src_scr,
  input  cplx_pkg::word_t            in_rd_data,
  input  cplx_pkg::word_t            scr_rd_data,
  input  cplx_pkg::word_t            gate_rd_data,
  output logic                       pipe_busy,
  output logic                       in_wr_en,
  output qsim_geom_pkg::state_addr_t in_wr_addr,
  output cplx_pkg::word_t            in_wr_data,
  output logic                       scr_wr_en,
  output qsim_geom_pkg::state_addr_t scr_wr_addr,
  output cplx_pkg::word_t            scr_wr_data,
  output logic                       out_wr_en,
  output qsim_geom_pkg::state_addr_t out_wr_addr,
  output cplx_pkg::word_t            out_wr_data
);

  logic v1, v2, v3;
  logic first1, last1, first2, last2;
  qsim_geom_pkg::state_addr_t row1, row2;
  cplx_pkg::cplx_t amp, mat, term, acc;
  logic signed [2*cplx_pkg::PART_W-1:0] p_rr, p_ii, p_ri, p_ir;
  logic signed [2*cplx_pkg::PART_W:0] re_full, im_full;

  // --------------------------------------------------
  // tag delay, valid bits
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      v1 <= 1'b0;
      v2 <= 1'b0;
      v3 <= 1'b0;
    end else begin
      v1 <= issue.valid;
      v2 <= v1;
      v3 <= v2;
    end
  end

  // tag follows the read data
  always_ff @(posedge clk) begin
    first1 <= issue.first;
    last1  <= issue.last;
    row1   <= issue.row;
    first2 <= first1;
    last2  <= last1;
    row2   <= row1;
  end

  // --------------------------------------------------
  // partial products
  // --------------------------------------------------
  assign amp = src_scr ? cplx_pkg::cplx_t'(scr_rd_data) : cplx_pkg::cplx_t'(in_rd_data);
  assign mat = cplx_pkg::cplx_t'(gate_rd_data);

  always_ff @(posedge clk) begin
    p_rr <= amp.re * mat.re;
    p_ii <= amp.im * mat.im;
    p_ri <= amp.re * mat.im;
    p_ir <= amp.im * mat.re;
  end

  // exact sum, then drop the fraction
  always_comb begin
    re_full = p_rr - p_ii;
    im_full = p_ri + p_ir;
    term.re = cplx_pkg::part_t'(re_full >>> cplx_pkg::FRAC_W);
    term.im = cplx_pkg::part_t'(im_full >>> cplx_pkg::FRAC_W);
  end

  // running row sum, wraps per part
  always_ff @(posedge clk) begin
    if (v2) begin
      acc.re <= first2 ? term.re : acc.re + term.re;
      acc.im <= first2 ? term.im : acc.im + term.im;
    end
  end

  // --------------------------------------------------
  // write-back on the last column
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      in_wr_en  <= 1'b0;
      scr_wr_en <= 1'b0;
      out_wr_en <= 1'b0;
    end else begin
      out_wr_en <= v2 && last2;
      // even gates fill the scratchpad, odd gates the input SRAM
      scr_wr_en <= v2 && last2 && !src_scr;
      in_wr_en  <= v2 && last2 && src_scr;
    end
  end

  always_ff @(posedge clk) begin
    out_wr_addr <= row2;
    scr_wr_addr <= row2;
    in_wr_addr  <= row2 + 1'b1;
  end

  assign out_wr_data = cplx_pkg::word_t'(acc);
  assign scr_wr_data = cplx_pkg::word_t'(acc);
  assign in_wr_data  = cplx_pkg::word_t'(acc);
  assign pipe_busy   = v1 || v2 || v3;

endmodule

//--- hdl/qsim_addr_gen.sv
// issues N*N elements back to back per gate in row-major order; num_qubits must be stable
`timescale 1ns/1ps

module qsim_addr_gen (
  input  logic                       clk,
  input  logic                       reset_n,
  input  qsim_geom_pkg::qubit_cnt_t  num_qubits,
  input  logic                       job_start,
  input  logic                       gate_start,
  input  logic                       src_scr,
  input  logic                       hdr_rd,
  output logic                       gen_busy,
  output qsim_geom_pkg::state_addr_t in_rd_addr,
  output qsim_geom_pkg::state_addr_t scr_rd_addr,
  output qsim_geom_pkg::gate_addr_t  gate_rd_addr,
  qsim_issue_if.gen                  issue
);

  qsim_geom_pkg::state_addr_t n_last;
  qsim_geom_pkg::gate_addr_t  n_sq;
  qsim_geom_pkg::state_addr_t col;
  qsim_geom_pkg::state_addr_t row;
  qsim_geom_pkg::gate_addr_t  gate_base;
  qsim_geom_pkg::gate_addr_t  row_off;
  logic                       col_wrap;
  logic                       gate_done;

  // --------------------------------------------------
  // geometry from the qubit count
  // --------------------------------------------------
  // N-1 and N*N
  assign n_last = (qsim_geom_pkg::state_addr_t'(1) << num_qubits) - 1'b1;
  assign n_sq   = qsim_geom_pkg::gate_addr_t'(1) << {num_qubits, 1'b0};

  assign col_wrap  = (col == n_last);
  assign gate_done = col_wrap && (row == n_last);

  // --------------------------------------------------
  // counters and gate base
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      gen_busy  <= 1'b0;
      col       <= '0;
      row       <= '0;
      gate_base <= '0;
    end else begin
      if (job_start) begin
        gate_base <= '0;
      end else if (gen_busy && gate_done) begin
        // step to the next matrix
        gate_base <= gate_base + n_sq;
      end
      if (gate_start) begin
        gen_busy <= 1'b1;
        col      <= '0;
        row      <= '0;
      end else if (gen_busy) begin
        if (col_wrap) begin
          col <= '0;
          row <= row + 1'b1;
        end else begin
          col <= col + 1'b1;
        end
        if (gate_done) gen_busy <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // read addresses, same cycle as the tag
  // --------------------------------------------------
  // element (row, col) of the current gate
  assign row_off      = qsim_geom_pkg::gate_addr_t'(row) << num_qubits;
  assign gate_rd_addr = gate_base + row_off + qsim_geom_pkg::gate_addr_t'(col);

  // input amplitudes start after the header word
  assign in_rd_addr  = (hdr_rd || src_scr) ? '0 : col + 1'b1;
  assign scr_rd_addr = src_scr ? col : '0;

  assign issue.valid = gen_busy;
  assign issue.first = (col == '0);
  assign issue.last  = col_wrap;
  assign issue.row   = row;

endmodule

//--- hdl/qsim_ctrl.sv
// one job at a time; header Q must be 1..4 and M 1..15, other values are not checked
`timescale 1ns/1ps

module qsim_ctrl (
  input  logic                      clk,
  input  logic                      reset_n,
  input  logic                      dut_valid,
  output logic                      dut_ready,
  input  cplx_pkg::word_t           in_rd_data,
  input  logic                      gen_busy,
  input  logic                      pipe_busy,
  output logic                      hdr_rd,
  output qsim_geom_pkg::qubit_cnt_t num_qubits,
  output logic                      job_start,
  output logic                      gate_start,
  output logic                      src_scr
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_HDR_FETCH,
    ST_HDR_CAPTURE,
    ST_RUN_GATE,
    ST_DRAIN,
    ST_NEXT_GATE
  } state_t;

  state_t                   state;
  state_t                   state_nxt;
  qsim_geom_pkg::gate_cnt_t num_gates;
  qsim_geom_pkg::gate_cnt_t gate_idx;
  logic                     last_gate;

  assign last_gate = (gate_idx == num_gates - 1'b1);

  // --------------------------------------------------
  // handshake and pulses
  // --------------------------------------------------
  assign dut_ready  = (state == ST_IDLE);
  // address 0 stays on the input SRAM while idle
  assign hdr_rd     = (state == ST_IDLE);
  assign job_start  = (state == ST_HDR_CAPTURE);
  assign gate_start = (state == ST_HDR_CAPTURE) || (state == ST_NEXT_GATE);

  // --------------------------------------------------
  // next state
  // --------------------------------------------------
  always_comb begin
    state_nxt = state;
    case (state)
      ST_IDLE:        if (dut_valid) state_nxt = ST_HDR_FETCH;
      // header word returns this cycle
      ST_HDR_FETCH:   state_nxt = ST_HDR_CAPTURE;
      ST_HDR_CAPTURE: state_nxt = ST_RUN_GATE;
      // wait for the last element to be issued
      ST_RUN_GATE:    if (!gen_busy) state_nxt = ST_DRAIN;
      // next gate reads what this one writes
      ST_DRAIN: begin
        if (!pipe_busy) state_nxt = last_gate ? ST_IDLE : ST_NEXT_GATE;
      end
      ST_NEXT_GATE:   state_nxt = ST_RUN_GATE;
      default:        state_nxt = ST_IDLE;
    endcase
  end

  // --------------------------------------------------
  // state, header fields, gate count, ping-pong
  // --------------------------------------------------
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      state      <= ST_IDLE;
      num_qubits <= '0;
      num_gates  <= '0;
      gate_idx   <= '0;
      src_scr    <= 1'b0;
    end else begin
      state <= state_nxt;
      if (state == ST_HDR_FETCH) begin
        num_qubits <= in_rd_data[qsim_geom_pkg::HDR_Q_LSB +: qsim_geom_pkg::QUBIT_W];
        num_gates  <= in_rd_data[qsim_geom_pkg::HDR_M_LSB +: qsim_geom_pkg::GATE_CNT_W];
        gate_idx   <= '0;
        // gate 0 always reads the input SRAM
        src_scr    <= 1'b0;
      end else if ((state == ST_DRAIN) && !pipe_busy && !last_gate) begin
        gate_idx <= gate_idx + 1'b1;
        // odd gates read the scratchpad
        src_scr  <= ~src_scr;
      end
    end
  end

endmodule

//--- hdl/qsim_issue_if.sv
// tag for one matrix element read; no back-pressure, the receiver takes every valid tag
`timescale 1ns/1ps

interface qsim_issue_if;

  // element issued this cycle
  logic valid;
  // column 0 of a row, restarts the sum
  logic first;
  // column N-1 of a row, triggers write-back
  logic last;
  // output row the element contributes to
  qsim_geom_pkg::state_addr_t row;

  // address generator side
  modport gen (output valid, output first, output last, output row);

  // arithmetic pipeline side
  modport pipe (input valid, input first, input last, input row);

endinterface

//--- hdl/cplx_pkg.sv
// amplitudes and gate elements are Q1.14 complex pairs; no saturation anywhere, sums wrap
package cplx_pkg;

  // --------------------------------------------------
  // fixed-point part format
  // --------------------------------------------------

  // one real or imaginary part
  localparam int PART_W = 16;

  // fraction bits per part, so 1.0 is 16384
  localparam int FRAC_W = 14;

  // --------------------------------------------------
  // memory word packing
  // --------------------------------------------------

  // real part in the upper half, imaginary in the lower half
  localparam int WORD_W = 2 * PART_W;

  // raw word on every SRAM data port
  typedef logic [WORD_W-1:0] word_t;

  // signed two's complement part
  typedef logic signed [PART_W-1:0] part_t;

  // member order matches the word layout
  typedef struct packed {
    part_t re;
    part_t im;
  } cplx_t;

endpackage

//--- hdl/qsim_geom_pkg.sv
// sizing assumes at most 4 qubits and 15 gates per job; header word layout fixed below
package qsim_geom_pkg;

  // --------------------------------------------------
  // problem size limits
  // --------------------------------------------------

  // largest qubit count the memories are sized for
  localparam int MAX_QUBITS = 4;

  // header field widths
  localparam int QUBIT_W    = 3;
  localparam int GATE_CNT_W = 4;

  // --------------------------------------------------
  // memory address widths
  // --------------------------------------------------

  // state memories hold the header plus 2^MAX_QUBITS amplitudes
  localparam int STATE_ADDR_W = MAX_QUBITS + 1;

  // 15 gates of 16x16 elements fit below 4096
  localparam int GATE_ADDR_W = 2 * MAX_QUBITS + GATE_CNT_W;

  // --------------------------------------------------
  // header word at input address 0
  // --------------------------------------------------

  // qubit count sits in the upper half
  localparam int HDR_Q_LSB = 16;
  // gate count sits in the lower half
  localparam int HDR_M_LSB = 0;

  // address and count types
  typedef logic [STATE_ADDR_W-1:0] state_addr_t;
  typedef logic [GATE_ADDR_W-1:0]  gate_addr_t;
  typedef logic [QUBIT_W-1:0]      qubit_cnt_t;

  // also used as the running gate index
  typedef logic [GATE_CNT_W-1:0]   gate_cnt_t;

endpackage
